/* verilog/regmap_pkg.sv */
package regmap_pkg;

	localparam int reg_count = 16;

	typedef logic [3:0]  index_t;
	typedef logic [4:0]  host_addr_t; // one bit wider than index_t, so out-of-range addresses exist
	typedef logic [31:0] word_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_slverr = 2'b10;

	// register layout
	localparam index_t version_id       = 4'd0;
	localparam index_t size_id          = 4'd1;
	localparam index_t max_burst_id     = 4'd2;
	localparam index_t burst_size_id    = 4'd3;
	localparam index_t scale_id         = 4'd4;
	localparam index_t reserved_base_id = 4'd5;  // 5..7
	localparam index_t test_base_id     = 4'd8;
	localparam index_t test_end_id      = 4'd12; // exclusive
	localparam index_t ceiling_id       = 4'd15;

	// reset contents
	localparam word_t fw_version     = 32'h0001_0300;
	localparam word_t max_burst      = 32'd64;
	localparam word_t max_scale      = 32'd15;
	localparam word_t ceiling_value  = 32'hffff_fffe;
	localparam word_t reserved_value = 32'hffff_ffff;

	function automatic logic is_readonly(index_t i);
		return i == version_id || i == size_id || i == max_burst_id ||
			(i >= reserved_base_id && i < test_base_id) || i == ceiling_id;
	endfunction

	typedef struct packed {
		index_t index;
		word_t  data;
	} wr_req_t;

	typedef struct packed {
		index_t index;
	} rd_req_t;

endpackage

/* verilog/chunk_receiver.sv */
`timescale 1ns/1ps

module chunk_receiver #(
	parameter type payload_t = logic [7:0],
	parameter int  BEAT_W    = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	input  logic [BEAT_W-1:0] in_beat,
	output logic              in_ready,
	output logic              full,
	output payload_t          payload,
	input  logic              take
);

	localparam int PW     = $bits(payload_t);
	localparam int NBEATS = (PW + BEAT_W - 1) / BEAT_W;
	localparam int SH_W   = NBEATS * BEAT_W;
	localparam int CNT_W  = $clog2(NBEATS + 1);

	logic [SH_W-1:0]  shreg;
	logic [CNT_W-1:0] cnt;
	logic             beat_in;

	assign in_ready = ~full; // back-pressure while a word waits
	assign beat_in  = in_valid & in_ready;
	assign payload  = payload_t'(shreg[PW-1:0]);

	always_ff @(posedge clk) begin
		if (rst) begin
			full <= 1'b0;
			cnt  <= '0;
		end else if (take) begin
			full <= 1'b0;
		end else if (beat_in) begin
			if (cnt == CNT_W'(NBEATS - 1)) begin
				full <= 1'b1;
				cnt  <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// new beats enter at the top, so the first one ends up in the lsbs
	always_ff @(posedge clk) begin
		if (beat_in)
			shreg <= (shreg >> BEAT_W) | (SH_W'(in_beat) << (SH_W - BEAT_W));
	end

	take_when_full: assert property (@(posedge clk) disable iff (rst) take |-> full)
		else $error("take asserted while receiver is not full");

endmodule

/* verilog/chunk_transmitter.sv */
`timescale 1ns/1ps

module chunk_transmitter #(
	parameter type payload_t = logic [7:0],
	parameter int  BEAT_W    = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              load,
	input  payload_t          payload,
	output logic              idle,
	output logic              out_valid,
	output logic [BEAT_W-1:0] out_beat,
	input  logic              out_ready
);

	localparam int PW     = $bits(payload_t);
	localparam int NBEATS = (PW + BEAT_W - 1) / BEAT_W;
	localparam int SH_W   = NBEATS * BEAT_W;
	localparam int CNT_W  = $clog2(NBEATS + 1);

	logic [SH_W-1:0]  shreg;
	logic [CNT_W-1:0] cnt;
	logic             busy;
	logic             start;
	logic             beat_out;

	assign idle      = ~busy;
	assign out_valid = busy;
	assign out_beat  = shreg[BEAT_W-1:0]; // lsbs leave first
	assign start     = load & ~busy;
	assign beat_out  = busy & out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt  <= '0;
		end else if (beat_out) begin
			if (cnt == CNT_W'(NBEATS - 1))
				busy <= 1'b0;
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			shreg <= SH_W'(payload);
		else if (beat_out)
			shreg <= shreg >> BEAT_W; // holds still while stalled
	end

	load_when_idle: assert property (@(posedge clk) disable iff (rst) load |-> idle)
		else $error("load asserted while transmitter is busy");

endmodule

/* verilog/host_req_handler.sv */
`timescale 1ns/1ps

module host_req_handler (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   waddr_full,
	input  logic                   wdata_full,
	input  logic                   raddr_full,
	input  regmap_pkg::host_addr_t waddr,
	input  regmap_pkg::word_t      wdata,
	input  regmap_pkg::host_addr_t raddr,
	output logic                   waddr_take,
	output logic                   wdata_take,
	output logic                   raddr_take,
	output logic                   wr_start,
	output regmap_pkg::wr_req_t    wr_req,
	input  logic                   wr_done,
	input  regmap_pkg::resp_t      wr_resp,
	output logic                   rd_start,
	output regmap_pkg::rd_req_t    rd_req,
	input  logic                   rd_done,
	input  regmap_pkg::word_t      rd_word,
	output logic                   resp_load,
	output logic                   rdata_load,
	input  logic                   resp_idle,
	input  logic                   rdata_idle,
	output regmap_pkg::resp_t      resp_out,
	output regmap_pkg::word_t      rdata_out
);
	import regmap_pkg::*;

	typedef enum logic {st_idle, st_wait_done} state_t;

	state_t wr_state;
	state_t rd_state;

	// anything past the map lands on the ceiling register
	function automatic index_t clamp_addr(host_addr_t a);
		if (a > host_addr_t'(ceiling_id))
			return ceiling_id;
		return index_t'(a);
	endfunction

	// write side, request stays on the receivers until taken
	assign wr_start     = (wr_state == st_idle) & waddr_full & wdata_full & resp_idle;
	assign wr_req.index = clamp_addr(waddr);
	assign wr_req.data  = wdata;
	assign waddr_take   = (wr_state == st_wait_done) & wr_done;
	assign wdata_take   = waddr_take;
	assign resp_load    = waddr_take;
	assign resp_out     = wr_resp;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= st_idle;
		end else if (wr_start) begin
			wr_state <= st_wait_done;
		end else if (waddr_take) begin
			wr_state <= st_idle;
		end
	end

	// read side runs independently
	assign rd_start     = (rd_state == st_idle) & raddr_full & rdata_idle;
	assign rd_req.index = clamp_addr(raddr);
	assign raddr_take   = (rd_state == st_wait_done) & rd_done;
	assign rdata_load   = raddr_take;
	assign rdata_out    = rd_word;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= st_idle;
		end else if (rd_start) begin
			rd_state <= st_wait_done;
		end else if (raddr_take) begin
			rd_state <= st_idle;
		end
	end

endmodule

/* verilog/shared_regmap.sv */
`timescale 1ns/1ps

module shared_regmap (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          wr_start,
	input  regmap_pkg::wr_req_t                           wr_req,
	output logic                                          wr_done,
	output regmap_pkg::resp_t                             wr_resp,
	input  logic                                          rd_start,
	input  regmap_pkg::rd_req_t                           rd_req,
	output logic                                          rd_done,
	output regmap_pkg::word_t                             rd_word,
	input  logic [regmap_pkg::reg_count-1:0]              rtl_write_req,
	input  logic [regmap_pkg::reg_count-1:0]              rtl_read_req,
	input  regmap_pkg::word_t [regmap_pkg::reg_count-1:0] rtl_wdata,
	input  logic                                          clr_rd,
	output regmap_pkg::word_t [regmap_pkg::reg_count-1:0] rtl_rdata,
	output logic [regmap_pkg::reg_count-1:0]              fresh
);
	import regmap_pkg::*;

	word_t                 regs [reg_count];
	word_t [reg_count-1:0] host_wd;
	logic [reg_count-1:0]  ro_mask;
	logic [reg_count-1:0]  rtl_we;
	logic [reg_count-1:0]  host_we;
	logic [reg_count-1:0]  host_rd;
	wr_req_t               wr_hold;
	rd_req_t               rd_hold;
	logic                  wr_pend, rd_pend;
	logic                  wr_grant, rd_grant;

	function automatic word_t reset_word(index_t i);
		if (i == version_id)
			return fw_version;
		if (i == size_id)
			return word_t'(reg_count);
		if (i == max_burst_id)
			return max_burst;
		if (i == ceiling_id)
			return ceiling_value;
		if (i >= reserved_base_id && i < test_base_id)
			return reserved_value;
		return '0;
	endfunction

	always_comb begin
		for (int i = 0; i < reg_count; i++)
			ro_mask[i] = is_readonly(index_t'(i));
	end

	assign rtl_we = rtl_write_req & ~ro_mask; // on-chip side can't touch read-only regs

	// host waits until nothing on-chip targets its index
	assign wr_grant = wr_pend & ~rtl_we[wr_hold.index] & ~rtl_read_req[wr_hold.index];
	assign rd_grant = rd_pend & ~rtl_we[rd_hold.index] & ~rtl_read_req[rd_hold.index];

	// host write rules, decoded per register
	always_comb begin
		host_we = '0;
		host_rd = '0;
		for (int i = 0; i < reg_count; i++)
			host_wd[i] = wr_hold.data;
		if (wr_grant && !ro_mask[wr_hold.index]) begin
			host_we[wr_hold.index] = 1'b1;
			if (wr_hold.index >= test_base_id && wr_hold.index < test_end_id) begin
				host_wd[wr_hold.index] = wr_hold.data - 32'd10;
				if (wr_hold.index != test_end_id - 1'b1) begin
					host_we[index_t'(wr_hold.index + 1'b1)] = 1'b1;
					host_wd[index_t'(wr_hold.index + 1'b1)] = wr_hold.data + 32'd10;
				end
			end else if (wr_hold.index == burst_size_id && wr_hold.data > max_burst) begin
				host_wd[wr_hold.index] = max_burst;
			end else if (wr_hold.index == scale_id && wr_hold.data > max_scale) begin
				host_wd[wr_hold.index] = max_scale;
			end
		end
		if (rd_grant)
			host_rd[rd_hold.index] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fresh     <= '0;
			rtl_rdata <= '0;
			for (int i = 0; i < reg_count; i++)
				regs[i] <= reset_word(index_t'(i));
		end else begin
			for (int i = 0; i < reg_count; i++) begin
				if (rtl_we[i]) begin // on-chip write wins
					regs[i]  <= rtl_wdata[i];
					fresh[i] <= 1'b1;
				end else if (host_we[i]) begin
					regs[i]  <= host_wd[i];
					fresh[i] <= 1'b1;
				end else if (rtl_read_req[i] || host_rd[i]) begin
					fresh[i] <= 1'b0;
				end
				if (clr_rd)
					rtl_rdata[i] <= '0;
				else if (rtl_read_req[i])
					rtl_rdata[i] <= regs[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_pend <= 1'b0;
			rd_pend <= 1'b0;
			wr_done <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			wr_done <= wr_grant;
			rd_done <= rd_grant;
			if (wr_start)
				wr_pend <= 1'b1;
			else if (wr_grant)
				wr_pend <= 1'b0;
			if (rd_start)
				rd_pend <= 1'b1;
			else if (rd_grant)
				rd_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_start)
			wr_hold <= wr_req;
		if (rd_start)
			rd_hold <= rd_req;
		if (wr_grant)
			wr_resp <= ro_mask[wr_hold.index] ? resp_slverr : resp_okay;
		if (rd_grant)
			rd_word <= regs[rd_hold.index];
	end

	one_write_in_flight: assert property (@(posedge clk) disable iff (rst) wr_start |-> !wr_pend)
		else $error("new host write while one is pending");

	// read-only regs never become fresh
	ro_never_fresh: assert property (@(posedge clk) disable iff (rst) (fresh & ro_mask) == '0)
		else $error("fresh bit set on a read-only register");

endmodule

/* verilog/regmap_slave.sv */
`timescale 1ns/1ps

module regmap_slave #(
	parameter int BEAT_W      = 8,
	parameter int ADDR_BEAT_W = 1
) (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          waddr_valid,
	input  logic [ADDR_BEAT_W-1:0]                        waddr_beat,
	output logic                                          waddr_ready,
	input  logic                                          wdata_valid,
	input  logic [BEAT_W-1:0]                             wdata_beat,
	output logic                                          wdata_ready,
	input  logic                                          raddr_valid,
	input  logic [ADDR_BEAT_W-1:0]                        raddr_beat,
	output logic                                          raddr_ready,
	output logic                                          rdata_valid,
	output logic [BEAT_W-1:0]                             rdata_beat,
	input  logic                                          rdata_ready,
	output logic                                          resp_valid,
	output logic [ADDR_BEAT_W-1:0]                        resp_beat,
	input  logic                                          resp_ready,
	input  logic [regmap_pkg::reg_count-1:0]              rtl_write_req,
	input  logic [regmap_pkg::reg_count-1:0]              rtl_read_req,
	input  regmap_pkg::word_t [regmap_pkg::reg_count-1:0] rtl_wdata,
	input  logic                                          clr_rd,
	output regmap_pkg::word_t [regmap_pkg::reg_count-1:0] rtl_rdata,
	output logic [regmap_pkg::reg_count-1:0]              fresh
);
	import regmap_pkg::*;

	host_addr_t waddr, raddr;
	word_t      wdata, rd_word, rdata_out;
	logic       waddr_full, wdata_full, raddr_full;
	logic       waddr_take, wdata_take, raddr_take;
	logic       wr_start, wr_done, rd_start, rd_done;
	wr_req_t    wr_req;
	rd_req_t    rd_req;
	resp_t      wr_resp, resp_out;
	logic       resp_load, rdata_load, resp_idle, rdata_idle;

	chunk_receiver #(.payload_t(host_addr_t), .BEAT_W(ADDR_BEAT_W)) u_waddr_rx (
		.clk(clk), .rst(rst),
		.in_valid(waddr_valid), .in_beat(waddr_beat), .in_ready(waddr_ready),
		.full(waddr_full), .payload(waddr), .take(waddr_take)
	);

	chunk_receiver #(.payload_t(word_t), .BEAT_W(BEAT_W)) u_wdata_rx (
		.clk(clk), .rst(rst),
		.in_valid(wdata_valid), .in_beat(wdata_beat), .in_ready(wdata_ready),
		.full(wdata_full), .payload(wdata), .take(wdata_take)
	);

	chunk_receiver #(.payload_t(host_addr_t), .BEAT_W(ADDR_BEAT_W)) u_raddr_rx (
		.clk(clk), .rst(rst),
		.in_valid(raddr_valid), .in_beat(raddr_beat), .in_ready(raddr_ready),
		.full(raddr_full), .payload(raddr), .take(raddr_take)
	);

	chunk_transmitter #(.payload_t(word_t), .BEAT_W(BEAT_W)) u_rdata_tx (
		.clk(clk), .rst(rst),
		.load(rdata_load), .payload(rdata_out), .idle(rdata_idle),
		.out_valid(rdata_valid), .out_beat(rdata_beat), .out_ready(rdata_ready)
	);

	// response codes go out on the narrow channel width
	chunk_transmitter #(.payload_t(resp_t), .BEAT_W(ADDR_BEAT_W)) u_resp_tx (
		.clk(clk), .rst(rst),
		.load(resp_load), .payload(resp_out), .idle(resp_idle),
		.out_valid(resp_valid), .out_beat(resp_beat), .out_ready(resp_ready)
	);

	host_req_handler u_handler (
		.clk(clk), .rst(rst),
		.waddr_full(waddr_full), .wdata_full(wdata_full), .raddr_full(raddr_full),
		.waddr(waddr), .wdata(wdata), .raddr(raddr),
		.waddr_take(waddr_take), .wdata_take(wdata_take), .raddr_take(raddr_take),
		.wr_start(wr_start), .wr_req(wr_req), .wr_done(wr_done), .wr_resp(wr_resp),
		.rd_start(rd_start), .rd_req(rd_req), .rd_done(rd_done), .rd_word(rd_word),
		.resp_load(resp_load), .rdata_load(rdata_load),
		.resp_idle(resp_idle), .rdata_idle(rdata_idle),
		.resp_out(resp_out), .rdata_out(rdata_out)
	);

	shared_regmap u_map (
		.clk(clk), .rst(rst),
		.wr_start(wr_start), .wr_req(wr_req), .wr_done(wr_done), .wr_resp(wr_resp),
		.rd_start(rd_start), .rd_req(rd_req), .rd_done(rd_done), .rd_word(rd_word),
		.rtl_write_req(rtl_write_req), .rtl_read_req(rtl_read_req),
		.rtl_wdata(rtl_wdata), .clr_rd(clr_rd),
		.rtl_rdata(rtl_rdata), .fresh(fresh)
	);

endmodule

/* test/regmap_slave_tb.sv */
`timescale 1ns/1ps

module regmap_slave_tb;
	import regmap_pkg::*;

	localparam int tmo_cycles = 200;

	logic                  clk, rst;
	logic                  waddr_valid, wdata_valid, raddr_valid;
	logic [0:0]            waddr_beat, raddr_beat, resp_beat;
	logic [7:0]            wdata_beat, rdata_beat;
	logic                  waddr_ready, wdata_ready, raddr_ready;
	logic                  rdata_valid, rdata_ready, resp_valid, resp_ready;
	logic [reg_count-1:0]  rtl_write_req, rtl_read_req, fresh;
	word_t [reg_count-1:0] rtl_wdata, rtl_rdata;
	logic                  clr_rd;
	logic                  hold_active; // on-chip write is parked on a register
	integer                seed;
	word_t                 model [reg_count];
	logic [reg_count-1:0]  model_fresh;

	regmap_slave UUT (
		.clk(clk), .rst(rst),
		.waddr_valid(waddr_valid), .waddr_beat(waddr_beat), .waddr_ready(waddr_ready),
		.wdata_valid(wdata_valid), .wdata_beat(wdata_beat), .wdata_ready(wdata_ready),
		.raddr_valid(raddr_valid), .raddr_beat(raddr_beat), .raddr_ready(raddr_ready),
		.rdata_valid(rdata_valid), .rdata_beat(rdata_beat), .rdata_ready(rdata_ready),
		.resp_valid(resp_valid), .resp_beat(resp_beat), .resp_ready(resp_ready),
		.rtl_write_req(rtl_write_req), .rtl_read_req(rtl_read_req),
		.rtl_wdata(rtl_wdata), .clr_rd(clr_rd),
		.rtl_rdata(rtl_rdata), .fresh(fresh)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		assert (got === exp)
		else abort_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	rdata_held: assert property (@(posedge clk) disable iff (rst)
		rdata_valid && !rdata_ready |=> rdata_valid && $stable(rdata_beat))
		else abort_run("read data beat changed or vanished while the host stalled");

	resp_held: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_beat))
		else abort_run("response beat changed or vanished while the host stalled");

	no_resp_on_hold: assert property (@(posedge clk) disable iff (rst) hold_active |-> !resp_valid)
		else abort_run("write response arrived while an on-chip write held the register");

	function automatic bit ro_index(input int i);
		return i inside {0, 1, 2, 5, 6, 7, 15};
	endfunction

	function automatic int map_index(input int a);
		return a > 15 ? 15 : a; // past the map reads the ceiling
	endfunction

	task automatic model_reset();
		for (int i = 0; i < reg_count; i++)
			model[i] = (i >= 5 && i < 8) ? 32'hffff_ffff : 32'h0;
		model[0]    = fw_version;
		model[1]    = 32'd16;
		model[2]    = 32'd64;
		model[15]   = 32'hffff_fffe;
		model_fresh = '0;
	endtask

	task automatic model_write(input int idx, input word_t d);
		if (idx >= 8 && idx < 12) begin
			model[idx] = d - 32'd10;
			if (idx < 11) begin // last test index has no partner
				model[idx+1]       = d + 32'd10;
				model_fresh[idx+1] = 1'b1;
			end
		end else if (idx == 3)
			model[idx] = d > 32'd64 ? 32'd64 : d;
		else if (idx == 4)
			model[idx] = d > 32'd15 ? 32'd15 : d;
		else
			model[idx] = d;
		model_fresh[idx] = 1'b1;
	endtask

	task automatic send_addr(input bit is_read, input host_addr_t a);
		int n;
		for (int i = 0; i < $bits(host_addr_t); i++) begin
			raddr_valid = is_read;
			waddr_valid = !is_read;
			raddr_beat  = a[i];
			waddr_beat  = a[i];
			n = 0;
			while (!(is_read ? raddr_ready : waddr_ready)) begin
				step();
				n++;
				if (n > tmo_cycles)
					abort_run("address receiver stayed busy and never took a beat");
			end
			step();
		end
		raddr_valid = 1'b0;
		waddr_valid = 1'b0;
	endtask

	task automatic send_data(input word_t d);
		int n;
		for (int i = 0; i < 4; i++) begin
			wdata_valid = 1'b1;
			wdata_beat  = d[8*i +: 8];
			n = 0;
			while (!wdata_ready) begin
				step();
				n++;
				if (n > tmo_cycles)
					abort_run("write data receiver stayed busy and never took a beat");
			end
			step();
		end
		wdata_valid = 1'b0;
	endtask

	// host side stalls about one cycle in four
	task automatic recv_beats(input bit is_resp, input int nbeats, output word_t w);
		int   k;
		int   n;
		logic go;
		w = '0;
		k = 0;
		n = 0;
		while (k < nbeats) begin
			go = ($random(seed) % 4) != 0;
			resp_ready  = is_resp & go;
			rdata_ready = !is_resp & go;
			if (is_resp && resp_valid && go) begin
				w[k] = resp_beat;
				k++;
			end else if (!is_resp && rdata_valid && go) begin
				w[8*k +: 8] = rdata_beat;
				k++;
			end
			step();
			n++;
			if (n > tmo_cycles)
				abort_run(is_resp ? "no write response came back" : "no read data came back");
		end
		resp_ready  = 1'b0;
		rdata_ready = 1'b0;
	endtask

	task automatic finish_write(input host_addr_t a, input word_t d);
		word_t r;
		int    idx;
		idx = map_index(a);
		recv_beats(1'b1, 2, r);
		check_word("resp_beat", r, ro_index(idx) ? resp_slverr : resp_okay);
		if (!ro_index(idx))
			model_write(idx, d);
		check_word("fresh", fresh, model_fresh);
	endtask

	task automatic host_write(input host_addr_t a, input word_t d);
		send_addr(1'b0, a);
		send_data(d);
		finish_write(a, d);
	endtask

	task automatic host_read(input host_addr_t a);
		word_t r;
		send_addr(1'b1, a);
		recv_beats(1'b0, 4, r);
		check_word($sformatf("rdata_beat[addr %0d]", a), r, model[map_index(a)]);
		model_fresh[map_index(a)] = 1'b0;
		check_word("fresh", fresh, model_fresh);
	endtask

	task automatic rtl_write(input int idx, input word_t d);
		rtl_write_req[idx] = 1'b1;
		rtl_wdata[idx]     = d;
		step();
		rtl_write_req[idx] = 1'b0;
		if (!ro_index(idx)) begin
			model[idx]       = d;
			model_fresh[idx] = 1'b1;
		end
		check_word("fresh", fresh, model_fresh);
	endtask

	task automatic rtl_read(input int idx);
		rtl_read_req[idx] = 1'b1;
		step();
		rtl_read_req[idx] = 1'b0;
		model_fresh[idx]  = 1'b0;
		check_word($sformatf("rtl_rdata[%0d]", idx), rtl_rdata[idx], model[idx]);
		check_word("fresh", fresh, model_fresh);
	endtask

	initial begin
		seed          = 42;
		rst           = 1'b1;
		waddr_valid   = 1'b0;
		wdata_valid   = 1'b0;
		raddr_valid   = 1'b0;
		waddr_beat    = '0;
		raddr_beat    = '0;
		wdata_beat    = '0;
		rdata_ready   = 1'b0;
		resp_ready    = 1'b0;
		rtl_write_req = '0;
		rtl_read_req  = '0;
		rtl_wdata     = '0;
		clr_rd        = 1'b0;
		hold_active   = 1'b0;
		model_reset();
		repeat (8) step();
		rst = 1'b0;
		check_word("valid outputs", {rdata_valid, resp_valid}, 2'b00);
		check_word("ready outputs", {waddr_ready, wdata_ready, raddr_ready}, 3'b111);
		check_word("fresh", fresh, '0);
		for (int i = 0; i < reg_count; i++)
			check_word($sformatf("rtl_rdata[%0d]", i), rtl_rdata[i], '0);

		for (int a = 0; a < 32; a++)
			host_read(host_addr_t'(a));

		host_write(5'd12, 32'h1234_5678);
		host_read(5'd12);
		host_write(5'd0, 32'hdead_beef); // read-only
		host_write(5'd31, 32'h0000_0001); // lands on the ceiling
		host_read(5'd0);
		host_read(5'd15);

		host_write(5'd3, 32'd100);
		host_read(5'd3);
		host_write(5'd3, 32'd20);
		host_read(5'd3);
		host_write(5'd4, 32'd99);
		host_read(5'd4);
		host_write(5'd4, 32'd7);
		host_read(5'd4);

		host_write(5'd8, 32'd1000);
		host_write(5'd11, 32'd500);
		for (int a = 8; a < 13; a++)
			host_read(host_addr_t'(a));

		rtl_write(13, 32'hcafe_0013);
		host_read(5'd13);
		rtl_write(0, 32'h5555_aaaa); // dropped, read-only
		host_read(5'd0);
		rtl_write(14, 32'h0bad_f00d);
		rtl_read(14);
		clr_rd = 1'b1;
		step();
		clr_rd = 1'b0;
		for (int i = 0; i < reg_count; i++)
			check_word($sformatf("rtl_rdata[%0d]", i), rtl_rdata[i], '0);

		// host write parked behind an on-chip write
		rtl_write_req[12] = 1'b1;
		rtl_wdata[12]     = 32'h7777_0000;
		hold_active       = 1'b1;
		step();
		model[12]       = 32'h7777_0000;
		model_fresh[12] = 1'b1;
		send_addr(1'b0, 5'd12);
		send_data(32'h0000_abcd);
		repeat (20) step();
		rtl_write_req[12] = 1'b0;
		hold_active       = 1'b0;
		finish_write(5'd12, 32'h0000_abcd);
		host_read(5'd12);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* src.f */
verilog/regmap_pkg.sv
verilog/chunk_receiver.sv
verilog/chunk_transmitter.sv
verilog/host_req_handler.sv
verilog/shared_regmap.sv
verilog/regmap_slave.sv
test/regmap_slave_tb.sv
